//--- Makefile
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f list.f --top-module tb_decoding_graph -o sim_decoding_graph

run: build
	./obj_dir/sim_decoding_graph +verilator+error+limit+1000 | tee sim.log
	grep -q "all tests passed" sim.log

lint:
	verilator --lint-only --timing --assert -f list.f --top-module tb_decoding_graph
	verilator --lint-only decoding_pkg.sv processing_unit.sv neighbor_link.sv decoding_graph.sv \
		--top-module decoding_graph

clean:
	rm -rf obj_dir sim.log

//--- decoding_graph.sv
`timescale 1ns/1ps

module decoding_graph (
    input  logic                                                     clk,
    input  logic                                                     reset,
    input  decoding_pkg::stage_e                                     global_stage_i,
    input  logic [decoding_pkg::PU_COUNT_PER_ROUND-1:0]              measurements_i,
    output decoding_pkg::address_t [decoding_pkg::PU_COUNT-1:0]      roots_o,
    output logic [decoding_pkg::PU_COUNT-1:0]                        odd_clusters_o,
    output logic [decoding_pkg::PU_COUNT-1:0]                        busy_o
);

    decoding_pkg::stage_e stage;   // Registered copy seen by every unit and link

    // Per unit wiring, indexed by unit address
    wire  decoding_pkg::link_view_t  [decoding_pkg::NEIGHBOR_COUNT-1:0]
          view [decoding_pkg::PU_COUNT];
    decoding_pkg::pu_exposed_t [decoding_pkg::NEIGHBOR_COUNT-1:0]
          exposed [decoding_pkg::PU_COUNT];
    logic [decoding_pkg::PU_COUNT-1:0] increase;
    logic [decoding_pkg::PU_COUNT-1:0] measurement_out;
    wire  [decoding_pkg::PU_COUNT-1:0] measurement_in;

    always_ff @(posedge clk) begin
        if (reset) begin
            stage <= decoding_pkg::STAGE_IDLE;
        end else begin
            stage <= global_stage_i;
        end
    end

    for (genvar u = 0; u < decoding_pkg::GRID_WIDTH_U; u++) begin : g_round
        for (genvar x = 0; x < decoding_pkg::GRID_WIDTH_X; x++) begin : g_row
            for (genvar z = 0; z < decoding_pkg::GRID_WIDTH_Z; z++) begin : g_col

                processing_unit #(
                    .ADDRESS(decoding_pkg::address_t'(u * decoding_pkg::PU_COUNT_PER_ROUND
                                                      + x * decoding_pkg::GRID_WIDTH_Z + z))
                ) i_pu (
                    .clk           (clk),
                    .reset         (reset),
                    .stage_i       (stage),
                    .measurement_i (measurement_in[u * decoding_pkg::PU_COUNT_PER_ROUND
                                                   + x * decoding_pkg::GRID_WIDTH_Z + z]),
                    .measurement_o (measurement_out[u * decoding_pkg::PU_COUNT_PER_ROUND
                                                    + x * decoding_pkg::GRID_WIDTH_Z + z]),
                    .neighbor_i    (view[u * decoding_pkg::PU_COUNT_PER_ROUND
                                         + x * decoding_pkg::GRID_WIDTH_Z + z]),
                    .exposed_o     (exposed[u * decoding_pkg::PU_COUNT_PER_ROUND
                                            + x * decoding_pkg::GRID_WIDTH_Z + z]),
                    .increase_o    (increase[u * decoding_pkg::PU_COUNT_PER_ROUND
                                             + x * decoding_pkg::GRID_WIDTH_Z + z]),
                    .root_o        (roots_o[u * decoding_pkg::PU_COUNT_PER_ROUND
                                            + x * decoding_pkg::GRID_WIDTH_Z + z]),
                    .odd_o         (odd_clusters_o[u * decoding_pkg::PU_COUNT_PER_ROUND
                                                   + x * decoding_pkg::GRID_WIDTH_Z + z]),
                    .busy_o        (busy_o[u * decoding_pkg::PU_COUNT_PER_ROUND
                                           + x * decoding_pkg::GRID_WIDTH_Z + z])
                );

                // Newest round reads the inputs, older rounds take the one above
                if (u == decoding_pkg::GRID_WIDTH_U - 1) begin : g_meas_top
                    assign measurement_in[u * decoding_pkg::PU_COUNT_PER_ROUND
                                          + x * decoding_pkg::GRID_WIDTH_Z + z]
                        = measurements_i[x * decoding_pkg::GRID_WIDTH_Z + z];
                end else begin : g_meas_chain
                    assign measurement_in[u * decoding_pkg::PU_COUNT_PER_ROUND
                                          + x * decoding_pkg::GRID_WIDTH_Z + z]
                        = measurement_out[(u + 1) * decoding_pkg::PU_COUNT_PER_ROUND
                                          + x * decoding_pkg::GRID_WIDTH_Z + z];
                end

                // Each unit owns the links toward south, east and up
                if (x < decoding_pkg::GRID_WIDTH_X - 1) begin : g_ns
                    neighbor_link i_link (
                        .clk          (clk),
                        .reset        (reset),
                        .stage_i      (stage),
                        .a_increase_i (increase[u * 9 + x * 3 + z]),
                        .b_increase_i (increase[u * 9 + (x + 1) * 3 + z]),
                        .a_data_i     (exposed[u * 9 + x * 3 + z][decoding_pkg::DIR_SOUTH]),
                        .b_data_i     (exposed[u * 9 + (x + 1) * 3 + z][decoding_pkg::DIR_NORTH]),
                        .a_view_o     (view[u * 9 + x * 3 + z][decoding_pkg::DIR_SOUTH]),
                        .b_view_o     (view[u * 9 + (x + 1) * 3 + z][decoding_pkg::DIR_NORTH])
                    );
                end else begin : g_ns_edge
                    assign view[u * 9 + x * 3 + z][decoding_pkg::DIR_SOUTH] = '0;
                end

                if (z < decoding_pkg::GRID_WIDTH_Z - 1) begin : g_we
                    neighbor_link i_link (
                        .clk          (clk),
                        .reset        (reset),
                        .stage_i      (stage),
                        .a_increase_i (increase[u * 9 + x * 3 + z]),
                        .b_increase_i (increase[u * 9 + x * 3 + z + 1]),
                        .a_data_i     (exposed[u * 9 + x * 3 + z][decoding_pkg::DIR_EAST]),
                        .b_data_i     (exposed[u * 9 + x * 3 + z + 1][decoding_pkg::DIR_WEST]),
                        .a_view_o     (view[u * 9 + x * 3 + z][decoding_pkg::DIR_EAST]),
                        .b_view_o     (view[u * 9 + x * 3 + z + 1][decoding_pkg::DIR_WEST])
                    );
                end else begin : g_we_edge
                    assign view[u * 9 + x * 3 + z][decoding_pkg::DIR_EAST] = '0;
                end

                if (u < decoding_pkg::GRID_WIDTH_U - 1) begin : g_ud
                    neighbor_link i_link (
                        .clk          (clk),
                        .reset        (reset),
                        .stage_i      (stage),
                        .a_increase_i (increase[u * 9 + x * 3 + z]),
                        .b_increase_i (increase[(u + 1) * 9 + x * 3 + z]),
                        .a_data_i     (exposed[u * 9 + x * 3 + z][decoding_pkg::DIR_UP]),
                        .b_data_i     (exposed[(u + 1) * 9 + x * 3 + z][decoding_pkg::DIR_DOWN]),
                        .a_view_o     (view[u * 9 + x * 3 + z][decoding_pkg::DIR_UP]),
                        .b_view_o     (view[(u + 1) * 9 + x * 3 + z][decoding_pkg::DIR_DOWN])
                    );
                end else begin : g_ud_edge
                    assign view[u * 9 + x * 3 + z][decoding_pkg::DIR_UP] = '0;
                end

                // Open sides on the low borders see nothing
                if (x == 0) begin : g_north_edge
                    assign view[u * 9 + x * 3 + z][decoding_pkg::DIR_NORTH] = '0;
                end
                if (z == 0) begin : g_west_edge
                    assign view[u * 9 + x * 3 + z][decoding_pkg::DIR_WEST] = '0;
                end
                if (u == 0) begin : g_down_edge
                    assign view[u * 9 + x * 3 + z][decoding_pkg::DIR_DOWN] = '0;
                end
            end
        end
    end

endmodule

//--- decoding_graph_assertions.sv
`timescale 1ns/1ps

module decoding_graph_assertions #(
    parameter decoding_pkg::address_t ADDRESS = '0
) (
    input logic                   clk,
    input logic                   reset,
    input decoding_pkg::stage_e   stage_i,
    input decoding_pkg::address_t root_o,
    input logic                   busy_o
);

    // Busy only follows an edge that ran a merge step
    busy_after_merge: assert property (@(posedge clk) disable iff (reset)
        busy_o |-> ($past(stage_i) == decoding_pkg::STAGE_MERGE))
        else begin
            $error("unit %0d busy after a cycle outside merge", ADDRESS);
            tb_decoding_graph.errors++;
        end

    root_never_rises: assert property (@(posedge clk) disable iff (reset)
        (stage_i == decoding_pkg::STAGE_MERGE) |=> (root_o <= $past(root_o)))
        else begin
            $error("unit %0d root increased during merge", ADDRESS);
            tb_decoding_graph.errors++;
        end

    root_after_load: assert property (@(posedge clk) disable iff (reset)
        (stage_i == decoding_pkg::STAGE_LOAD) |=> (root_o == ADDRESS))
        else begin
            $error("unit %0d root is not its own address after load", ADDRESS);
            tb_decoding_graph.errors++;
        end

endmodule

//--- decoding_pkg.sv
package decoding_pkg;

    // Grid geometry, one round is GRID_WIDTH_X by GRID_WIDTH_Z
    localparam int GRID_WIDTH_X = 3;
    localparam int GRID_WIDTH_Z = 3;
    localparam int GRID_WIDTH_U = 2;   // Rounds stacked in time

    localparam int PU_COUNT_PER_ROUND = GRID_WIDTH_X * GRID_WIDTH_Z;
    localparam int PU_COUNT           = PU_COUNT_PER_ROUND * GRID_WIDTH_U;
    localparam int NEIGHBOR_COUNT     = 6;
    localparam int ADDRESS_WIDTH      = $clog2(PU_COUNT);

    // Every link carries the same weight
    localparam int MAX_WEIGHT   = 2;
    localparam int WEIGHT_WIDTH = $clog2(MAX_WEIGHT + 1);

    typedef enum logic [1:0] {
        STAGE_IDLE,
        STAGE_LOAD,
        STAGE_GROW,
        STAGE_MERGE
    } stage_e;

    // First six values double as neighbor slot indices
    typedef enum logic [2:0] {
        DIR_NORTH,   // x - 1
        DIR_SOUTH,   // x + 1
        DIR_WEST,    // z - 1
        DIR_EAST,    // z + 1
        DIR_DOWN,    // Older round
        DIR_UP,      // Newer round
        DIR_SELF     // No parent, unit is a cluster root
    } direction_e;

    // Address is round * PU_COUNT_PER_ROUND + x * GRID_WIDTH_Z + z
    typedef logic [ADDRESS_WIDTH-1:0] address_t;

    // What a unit shows toward one of its sides
    typedef struct packed {
        address_t root;
        logic     odd;
        logic     parity;     // Parity of the subtree below this unit
        logic     is_parent;  // Unit on this side is my parent
    } pu_exposed_t;

    // What a link hands to one of its ends
    typedef struct packed {
        logic        grown;
        pu_exposed_t data;    // Zero until the link is fully grown
    } link_view_t;

endpackage

//--- list.f
+incdir+.
decoding_pkg.sv
processing_unit.sv
neighbor_link.sv
decoding_graph.sv
decoding_graph_assertions.sv
tb_decoding_graph.sv

//--- neighbor_link.sv
`timescale 1ns/1ps

module neighbor_link (
    input  logic                      clk,
    input  logic                      reset,
    input  decoding_pkg::stage_e      stage_i,
    input  logic                      a_increase_i,
    input  logic                      b_increase_i,
    input  decoding_pkg::pu_exposed_t a_data_i,
    input  decoding_pkg::pu_exposed_t b_data_i,
    output decoding_pkg::link_view_t  a_view_o,
    output decoding_pkg::link_view_t  b_view_o
);

    logic [decoding_pkg::WEIGHT_WIDTH-1:0] counter;       // Growth so far
    logic [decoding_pkg::WEIGHT_WIDTH:0]   counter_sum;   // Spare bit keeps the carry
    logic                                  grown;

    // Each odd end adds one step per grow cycle
    assign counter_sum = {1'b0, counter}
                       + {{decoding_pkg::WEIGHT_WIDTH{1'b0}}, a_increase_i}
                       + {{decoding_pkg::WEIGHT_WIDTH{1'b0}}, b_increase_i};

    assign grown = (counter == (decoding_pkg::WEIGHT_WIDTH)'(decoding_pkg::MAX_WEIGHT));

    always_ff @(posedge clk) begin
        if (reset) begin
            counter <= '0;
        end else begin
            case (stage_i)
                decoding_pkg::STAGE_LOAD: begin
                    counter <= '0;
                end
                decoding_pkg::STAGE_GROW: begin
                    if (counter_sum >= (decoding_pkg::WEIGHT_WIDTH + 1)'(decoding_pkg::MAX_WEIGHT)) begin
                        counter <= (decoding_pkg::WEIGHT_WIDTH)'(decoding_pkg::MAX_WEIGHT);
                    end else begin
                        counter <= counter_sum[decoding_pkg::WEIGHT_WIDTH-1:0];
                    end
                end
                default: begin
                    counter <= counter;   // Merge and idle hold the edge
                end
            endcase
        end
    end

    // Each side sees the other one only once the edge is fully grown
    always_comb begin
        a_view_o.grown = grown;
        a_view_o.data  = grown ? b_data_i : '0;
        b_view_o.grown = grown;
        b_view_o.data  = grown ? a_data_i : '0;
    end

endmodule

//--- processing_unit.sv
`timescale 1ns/1ps

module processing_unit #(
    parameter decoding_pkg::address_t ADDRESS = '0
) (
    input  logic                                                         clk,
    input  logic                                                         reset,
    input  decoding_pkg::stage_e                                         stage_i,
    input  logic                                                         measurement_i,
    output logic                                                         measurement_o,
    input  decoding_pkg::link_view_t  [decoding_pkg::NEIGHBOR_COUNT-1:0] neighbor_i,
    output decoding_pkg::pu_exposed_t [decoding_pkg::NEIGHBOR_COUNT-1:0] exposed_o,
    output logic                                                         increase_o,
    output decoding_pkg::address_t                                       root_o,
    output logic                                                         odd_o,
    output logic                                                         busy_o
);

    logic                     defect;   // Measurement held by this unit
    decoding_pkg::address_t   root;
    decoding_pkg::direction_e parent;
    logic                     parity;
    logic                     odd;
    logic                     busy;

    decoding_pkg::address_t   min_root;   // Smallest root seen over grown links
    decoding_pkg::direction_e min_dir;
    logic                     parity_next;
    logic                     parent_odd;
    logic                     odd_next;
    logic                     changed;

    // Step 1 of merge, lowest direction wins a tie because of the strict compare
    always_comb begin
        min_root = root;
        min_dir  = parent;
        for (int d = 0; d < decoding_pkg::NEIGHBOR_COUNT; d++) begin
            if (neighbor_i[d].grown && (neighbor_i[d].data.root < min_root)) begin
                min_root = neighbor_i[d].data.root;
                min_dir  = decoding_pkg::direction_e'(d);
            end
        end
    end

    // Step 2, children report their subtree parity up the tree
    always_comb begin
        parity_next = defect;
        for (int d = 0; d < decoding_pkg::NEIGHBOR_COUNT; d++) begin
            parity_next = parity_next ^ (neighbor_i[d].grown
                                         & neighbor_i[d].data.is_parent
                                         & neighbor_i[d].data.parity);
        end
    end

    // Step 3, the root decides and the verdict flows back down
    always_comb begin
        parent_odd = 1'b0;
        for (int d = 0; d < decoding_pkg::NEIGHBOR_COUNT; d++) begin
            if (parent == decoding_pkg::direction_e'(d)) begin
                parent_odd = neighbor_i[d].data.odd;
            end
        end
        odd_next = (parent == decoding_pkg::DIR_SELF) ? parity : parent_odd;
    end

    assign changed = (min_root != root) || (parity_next != parity) || (odd_next != odd);

    always_ff @(posedge clk) begin
        if (reset) begin
            defect <= 1'b0;
            root   <= ADDRESS;
            parent <= decoding_pkg::DIR_SELF;
            parity <= 1'b0;
            odd    <= 1'b0;
            busy   <= 1'b0;
        end else begin
            busy <= 1'b0;   // Only a merge step can keep the unit busy
            case (stage_i)
                decoding_pkg::STAGE_LOAD: begin
                    defect <= measurement_i;
                    root   <= ADDRESS;   // Every unit starts as its own cluster
                    parent <= decoding_pkg::DIR_SELF;
                    parity <= measurement_i;
                    odd    <= measurement_i;
                end
                decoding_pkg::STAGE_MERGE: begin
                    root   <= min_root;
                    parent <= min_dir;
                    parity <= parity_next;
                    odd    <= odd_next;
                    busy   <= changed;
                end
                default: begin
                    defect <= defect;   // Grow and idle leave the unit alone
                end
            endcase
        end
    end

    // Same data on every side, only the parent marker differs
    always_comb begin
        for (int d = 0; d < decoding_pkg::NEIGHBOR_COUNT; d++) begin
            exposed_o[d].root      = root;
            exposed_o[d].odd       = odd;
            exposed_o[d].parity    = parity;
            exposed_o[d].is_parent = (parent == decoding_pkg::direction_e'(d));
        end
    end

    assign measurement_o = defect;   // Shifts one round down on the next load
    assign increase_o    = odd;
    assign root_o        = root;
    assign odd_o         = odd;
    assign busy_o        = busy;

endmodule

//--- tb_cluster_model.svh
`ifndef TB_CLUSTER_MODEL_SVH
`define TB_CLUSTER_MODEL_SVH

// Reference union-find over the grown links, same growth rule as the graph
logic model_defect [decoding_pkg::PU_COUNT];
logic model_odd    [decoding_pkg::PU_COUNT];
int   model_root   [decoding_pkg::PU_COUNT];
int   link_growth  [decoding_pkg::PU_COUNT][3];   // Toward south, east and up
int   set_parent   [decoding_pkg::PU_COUNT];

// Far end of the link leaving unit a on one side, -1 past the border
function automatic int far_end(input int a, input int side);
    int u;
    int x;
    int z;
    u = a / decoding_pkg::PU_COUNT_PER_ROUND;
    x = (a % decoding_pkg::PU_COUNT_PER_ROUND) / decoding_pkg::GRID_WIDTH_Z;
    z = a % decoding_pkg::GRID_WIDTH_Z;
    case (side)
        0: return (x < decoding_pkg::GRID_WIDTH_X - 1) ? a + decoding_pkg::GRID_WIDTH_Z : -1;
        1: return (z < decoding_pkg::GRID_WIDTH_Z - 1) ? a + 1 : -1;
        default: return (u < decoding_pkg::GRID_WIDTH_U - 1)
                        ? a + decoding_pkg::PU_COUNT_PER_ROUND : -1;
    endcase
endfunction

function automatic void model_load(input logic [decoding_pkg::PU_COUNT_PER_ROUND-1:0] older,
                                   input logic [decoding_pkg::PU_COUNT_PER_ROUND-1:0] newer);
    for (int a = 0; a < decoding_pkg::PU_COUNT; a++) begin
        if (a < decoding_pkg::PU_COUNT_PER_ROUND) begin
            model_defect[a] = older[a];   // Round 0 keeps the first vector
        end else begin
            model_defect[a] = newer[a - decoding_pkg::PU_COUNT_PER_ROUND];
        end
        model_odd[a]  = model_defect[a];
        model_root[a] = a;
        for (int s = 0; s < 3; s++) begin
            link_growth[a][s] = 0;
        end
    end
endfunction

// One step per odd end, capped at the link weight
function automatic void model_grow();
    int b;
    for (int a = 0; a < decoding_pkg::PU_COUNT; a++) begin
        for (int s = 0; s < 3; s++) begin
            b = far_end(a, s);
            if (b >= 0) begin
                link_growth[a][s] += int'(model_odd[a]) + int'(model_odd[b]);
                if (link_growth[a][s] > decoding_pkg::MAX_WEIGHT) begin
                    link_growth[a][s] = decoding_pkg::MAX_WEIGHT;
                end
            end
        end
    end
endfunction

function automatic int find_set(input int a);
    int r;
    r = a;
    while (set_parent[r] != r) begin
        r = set_parent[r];
    end
    return r;
endfunction

function automatic void model_merge();
    int   b;
    int   ra;
    int   rb;
    logic parity [decoding_pkg::PU_COUNT];
    for (int a = 0; a < decoding_pkg::PU_COUNT; a++) begin
        set_parent[a] = a;
        parity[a]     = 1'b0;
    end
    for (int a = 0; a < decoding_pkg::PU_COUNT; a++) begin
        for (int s = 0; s < 3; s++) begin
            b = far_end(a, s);
            if (b >= 0 && link_growth[a][s] == decoding_pkg::MAX_WEIGHT) begin
                ra = find_set(a);
                rb = find_set(b);
                // The smaller address always stays the set root
                if (ra < rb) begin
                    set_parent[rb] = ra;
                end else if (rb < ra) begin
                    set_parent[ra] = rb;
                end
            end
        end
    end
    for (int a = 0; a < decoding_pkg::PU_COUNT; a++) begin
        ra         = find_set(a);
        parity[ra] = parity[ra] ^ model_defect[a];
    end
    for (int a = 0; a < decoding_pkg::PU_COUNT; a++) begin
        ra            = find_set(a);
        model_root[a] = ra;
        model_odd[a]  = parity[ra];
    end
endfunction

`endif

//--- tb_decoding_graph.sv
`timescale 1ns/1ps

module tb_decoding_graph;

    localparam int CLK_PERIOD      = 40;
    localparam int ROW_COUNT       = 12;
    localparam int MAX_ITER        = 6;   // Largest iteration limit in the table
    localparam int MERGE_BOUND     = 3 * decoding_pkg::PU_COUNT + 4;
    localparam int WATCHDOG_CYCLES = (ROW_COUNT + 4) * MAX_ITER * (MERGE_BOUND + 6);

    typedef struct packed {
        logic [decoding_pkg::PU_COUNT_PER_ROUND-1:0] round0;   // Loaded first and ends in round 0
        logic [decoding_pkg::PU_COUNT_PER_ROUND-1:0] round1;
        logic [3:0]                                  max_iter;
    } row_t;

    logic                                              clk;
    logic                                              reset;
    decoding_pkg::stage_e                              global_stage_i;
    logic [decoding_pkg::PU_COUNT_PER_ROUND-1:0]       measurements_i;
    decoding_pkg::address_t [decoding_pkg::PU_COUNT-1:0] roots_o;
    logic [decoding_pkg::PU_COUNT-1:0]                 odd_clusters_o;
    logic [decoding_pkg::PU_COUNT-1:0]                 busy_o;

    int     errors = 0;
    int     checks = 0;
    integer seed;
    row_t   rows [ROW_COUNT];

    `include "tb_cluster_model.svh"

    decoding_graph i_dut (
        .clk            (clk),
        .reset          (reset),
        .global_stage_i (global_stage_i),
        .measurements_i (measurements_i),
        .roots_o        (roots_o),
        .odd_clusters_o (odd_clusters_o),
        .busy_o         (busy_o)
    );

    bind processing_unit decoding_graph_assertions #(
        .ADDRESS(ADDRESS)
    ) i_assertions (
        .clk     (clk),
        .reset   (reset),
        .stage_i (stage_i),
        .root_o  (root_o),
        .busy_o  (busy_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_root(input int a, input int expected);
        checks++;
        assert (int'(roots_o[a]) == expected) else begin
            $display("FAIL %0t roots_o[%0d] expected %0d actual %0d",
                     $time, a, expected, roots_o[a]);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input int a, input logic expected,
                              input logic actual);
        checks++;
        assert (actual == expected) else begin
            $display("FAIL %0t %s[%0d] expected %0b actual %0b", $time, name, a, expected, actual);
            errors++;
        end
    endtask

    task automatic compare_with_model();
        for (int a = 0; a < decoding_pkg::PU_COUNT; a++) begin
            check_root(a, model_root[a]);
            check_flag("odd_clusters_o", a, model_odd[a], odd_clusters_o[a]);
        end
    endtask

    // The DUT registers the stage, so the data trails the stage by one cycle
    task automatic load_rounds(input logic [decoding_pkg::PU_COUNT_PER_ROUND-1:0] older,
                               input logic [decoding_pkg::PU_COUNT_PER_ROUND-1:0] newer);
        @(negedge clk);
        global_stage_i = decoding_pkg::STAGE_LOAD;
        measurements_i = older;
        @(negedge clk);
        @(negedge clk);
        global_stage_i = decoding_pkg::STAGE_IDLE;
        measurements_i = newer;
        @(negedge clk);
        measurements_i = '0;
        model_load(older, newer);
    endtask

    task automatic grow_and_merge();
        int cycles;
        @(negedge clk);
        global_stage_i = decoding_pkg::STAGE_GROW;   // Exactly one grow edge
        @(negedge clk);
        global_stage_i = decoding_pkg::STAGE_MERGE;
        repeat (2) @(negedge clk);   // First busy value of this merge
        cycles = 0;
        while (busy_o != '0 && cycles < MERGE_BOUND) begin
            @(negedge clk);
            cycles++;
        end
        checks++;
        assert (busy_o == '0) else begin
            $display("Merge still busy after %0d cycles at %0t", MERGE_BOUND, $time);
            errors++;
        end
        global_stage_i = decoding_pkg::STAGE_IDLE;
        model_grow();
        model_merge();
        compare_with_model();
    endtask

    task automatic fill_table();
        logic [31:0] word_a;
        logic [31:0] word_b;
        seed    = 67;
        rows[0] = '{round0: 9'h010, round1: 9'h010, max_iter: 4'd3};   // Vertical pair
        rows[1] = '{round0: 9'h100, round1: 9'h000, max_iter: 4'd4};   // Lone defect
        rows[2] = '{round0: 9'h003, round1: 9'h100, max_iter: 4'd5};   // Three defects
        rows[3] = '{round0: 9'h038, round1: 9'h008, max_iter: 4'd6};
        for (int i = 4; i < ROW_COUNT; i++) begin
            word_a           = $random(seed);
            word_b           = $random(seed);
            rows[i].round0   = word_a[8:0] & word_b[8:0];   // About one defect in four
            rows[i].round1   = word_a[24:16] & word_b[24:16];
            rows[i].max_iter = 4'd4;
        end
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout, the run did not end within %0d cycles", WATCHDOG_CYCLES);
        $display("tests failed");
        $finish;
    end

    initial begin
        int iter;
        clk            = 1'b0;
        reset          = 1'b1;
        global_stage_i = decoding_pkg::STAGE_IDLE;
        measurements_i = '0;
        fill_table();
        repeat (8) @(negedge clk);
        reset = 1'b0;
        for (int a = 0; a < decoding_pkg::PU_COUNT; a++) begin
            check_root(a, a);
            check_flag("odd_clusters_o", a, 1'b0, odd_clusters_o[a]);
            check_flag("busy_o", a, 1'b0, busy_o[a]);
        end

        load_rounds(9'h0a5, 9'h15a);
        compare_with_model();   // Odd bits equal the loaded defects

        // Defects at units 0 and 2 need two grow steps to reach unit 1
        load_rounds(9'h005, 9'h000);
        grow_and_merge();
        check_root(0, 0);
        check_root(2, 2);
        check_flag("odd_clusters_o", 0, 1'b1, odd_clusters_o[0]);
        check_flag("odd_clusters_o", 2, 1'b1, odd_clusters_o[2]);
        grow_and_merge();
        for (int a = 0; a < 3; a++) begin
            check_root(a, 0);
        end
        for (int a = 0; a < decoding_pkg::PU_COUNT; a++) begin
            check_flag("odd_clusters_o", a, 1'b0, odd_clusters_o[a]);
        end

        repeat (3) @(negedge clk);
        compare_with_model();   // Idle cycles keep the settled clusters

        for (int r = 0; r < ROW_COUNT; r++) begin
            load_rounds(rows[r].round0, rows[r].round1);
            compare_with_model();
            iter = 0;
            while (odd_clusters_o != '0 && iter < int'(rows[r].max_iter)) begin
                grow_and_merge();
                iter++;
            end
        end

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
